// ==== Makefile ====
# Verilator build and run for the serial EEPROM subsystem

VERILATOR ?= verilator
TOP       ?= eeprom_sys_tb
FLIST     ?= eeprom_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL CHECKS PASSED

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/bus_master.sv ====
`timescale 1ns/1ns

module bus_master (
    input  logic        scl,
    input  logic        rst,
    input  logic        cmd_valid,
    input  logic [7:0]  cmd_ctrl,
    input  logic [7:0]  cmd_addr,
    input  logic [7:0]  cmd_wdata,
    output logic        busy,
    output logic        rd_valid,
    output logic [7:0]  rd_data,
    output logic        nack,
    serial_if.master    link
);

    typedef enum logic [1:0] {
        m_idle,
        m_send,
        m_tail,
        m_recv
    } mst_state_t;

    mst_state_t  state;
    logic [23:0] frame_sr;
    logic [7:0]  ret_sr;
    logic [4:0]  bit_cnt;
    logic        is_rd;
    logic [4:0]  last_bit;

    // read frames stop after the address byte
    assign last_bit = is_rd ? 5'd15 : 5'd23;
    assign link.sda = frame_sr[23];

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state       <= m_idle;
            busy        <= 1'b0;
            rd_valid    <= 1'b0;
            nack        <= 1'b0;
            bit_cnt     <= '0;
            link.frame  <= 1'b0;
            link.bit_en <= 1'b0;
        end
        else
        begin
            rd_valid <= 1'b0;
            nack     <= 1'b0;
            case (state)
                m_idle:
                begin
                    if (cmd_valid)
                    begin
                        state       <= m_send;
                        busy        <= 1'b1;
                        link.frame  <= 1'b1;
                        link.bit_en <= 1'b1;
                        bit_cnt     <= '0;
                    end
                end
                m_send:
                begin
                    if (link.nak)
                    begin
                        // device type rejected so the frame is dropped
                        state       <= m_idle;
                        busy        <= 1'b0;
                        nack        <= 1'b1;
                        link.frame  <= 1'b0;
                        link.bit_en <= 1'b0;
                    end
                    else if (bit_cnt == last_bit)
                    begin
                        link.bit_en <= 1'b0;
                        bit_cnt     <= '0;
                        state       <= is_rd ? m_recv : m_tail;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 5'd1;
                    end
                end
                m_tail:
                begin
                    // one cycle for the decoder to issue the write
                    state      <= m_idle;
                    busy       <= 1'b0;
                    link.frame <= 1'b0;
                end
                m_recv:
                begin
                    if (link.ret_en)
                    begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt == 5'd7)
                        begin
                            state      <= m_idle;
                            busy       <= 1'b0;
                            rd_valid   <= 1'b1;
                            link.frame <= 1'b0;
                            bit_cnt    <= '0;
                        end
                    end
                end
                default:
                    state <= m_idle;
            endcase
        end
    end

    always_ff @(posedge scl)
    begin
        if (state == m_idle && cmd_valid)
        begin
            frame_sr <= {cmd_ctrl, cmd_addr, cmd_wdata};
            is_rd    <= cmd_ctrl[0];
        end
        else if (link.bit_en)
        begin
            frame_sr <= {frame_sr[22:0], 1'b0};
        end
        if (state == m_recv && link.ret_en)
        begin
            ret_sr <= {ret_sr[6:0], link.ret_sda};
            if (bit_cnt == 5'd7)
                rd_data <= {ret_sr[6:0], link.ret_sda};
        end
    end

    assert property (@(posedge scl) disable iff (rst) link.bit_en |-> link.frame)
        else $error("bit_en high outside a frame");

endmodule

// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

    // upper nibble of every valid control byte
    localparam logic [3:0] dev_type = 4'b1010;

    // widest address the control and address bytes can form
    localparam int addr_max_w = 11;

    typedef struct packed {
        logic                  wr;
        logic [addr_max_w-1:0] addr;
        logic [7:0]            wdata;
    } mem_req_t;

    // decoder frame phase
    typedef enum logic [2:0] {
        dec_idle,
        dec_ctrl,
        dec_addr,
        dec_data,
        dec_wait
    } dec_state_t;

endpackage

// ==== design/eeprom_sys.sv ====
`timescale 1ns/1ns

module eeprom_sys
    import eeprom_pkg::*;
#(
    parameter int ADDR_W = 11
)
(
    input  logic       scl,
    input  logic       rst,
    input  logic       cmd_valid,
    input  logic [7:0] cmd_ctrl,
    input  logic [7:0] cmd_addr,
    input  logic [7:0] cmd_wdata,
    output logic       busy,
    output logic       rd_valid,
    output logic [7:0] rd_data,
    output logic       nack
);

    // decode to execute
    logic     req_valid;
    mem_req_t req;

    // execute to result
    logic       mem_rd_valid;
    logic [7:0] mem_rd_data;

    serial_if link ();

    bus_master u_bus_master (
        .scl       (scl),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ctrl  (cmd_ctrl),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .nack      (nack),
        .link      (link.master)
    );

    frame_decoder #(.ADDR_W(ADDR_W)) u_frame_decoder (
        .scl       (scl),
        .rst       (rst),
        .link      (link.slave),
        .req_valid (req_valid),
        .req       (req)
    );

    mem_access #(.ADDR_W(ADDR_W)) u_mem_access (
        .scl       (scl),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .rd_valid  (mem_rd_valid),
        .rd_data   (mem_rd_data)
    );

    read_shifter u_read_shifter (
        .scl      (scl),
        .rst      (rst),
        .rd_valid (mem_rd_valid),
        .rd_data  (mem_rd_data),
        .link     (link.slave)
    );

endmodule

// ==== design/frame_decoder.sv ====
`timescale 1ns/1ns

module frame_decoder
    import eeprom_pkg::*;
#(
    parameter int ADDR_W = 11
)
(
    input  logic     scl,
    input  logic     rst,
    serial_if.slave  link,
    output logic     req_valid,
    output mem_req_t req
);

    dec_state_t            state;
    logic [2:0]            bit_cnt;
    logic [6:0]            byte_sr;
    logic [3:0]            ctrl_q;
    logic [ADDR_W-1:0]     addr_q;
    logic [7:0]            new_byte;
    logic                  byte_done;
    logic [addr_max_w-1:0] full_addr;
    logic [ADDR_W-1:0]     cur_addr;

    always_comb
    begin
        new_byte  = {byte_sr, link.sda};
        byte_done = link.bit_en && (bit_cnt == 3'd7) && (state != dec_wait);
        // block bits from the control byte, then the address byte
        full_addr = {ctrl_q[3:1], new_byte};
        cur_addr  = full_addr[ADDR_W-1:0];
    end

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state     <= dec_idle;
            bit_cnt   <= '0;
            req_valid <= 1'b0;
            link.nak  <= 1'b0;
        end
        else
        begin
            req_valid <= 1'b0;
            link.nak  <= 1'b0;
            if (!link.frame)
            begin
                state   <= dec_idle;
                bit_cnt <= '0;
            end
            else if (link.bit_en && state != dec_wait)
            begin
                bit_cnt <= bit_cnt + 3'd1;
                case (state)
                    dec_idle:
                        state <= dec_ctrl;
                    dec_ctrl:
                        if (byte_done)
                        begin
                            if (new_byte[7:4] != dev_type)
                            begin
                                link.nak <= 1'b1;
                                state    <= dec_wait;
                            end
                            else
                                state <= dec_addr;
                        end
                    dec_addr:
                        if (byte_done)
                        begin
                            if (ctrl_q[0])
                            begin
                                req_valid <= 1'b1;
                                state     <= dec_wait;
                            end
                            else
                                state <= dec_data;
                        end
                    dec_data:
                        if (byte_done)
                        begin
                            req_valid <= 1'b1;
                            state     <= dec_wait;
                        end
                    default:
                        state <= dec_wait;
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (link.bit_en)
            byte_sr <= new_byte[6:0];
        if (byte_done && state == dec_ctrl)
            ctrl_q <= new_byte[3:0];
        if (byte_done && state == dec_addr)
            addr_q <= cur_addr;
        if (byte_done && (state == dec_addr || state == dec_data))
        begin
            req.wr    <= (state == dec_data);
            req.addr  <= addr_max_w'(state == dec_data ? addr_q : cur_addr);
            req.wdata <= new_byte;
        end
    end

    // the last phase ends with the master's last bit, inside the frame
    assert property (@(posedge scl) disable iff (rst)
        req_valid |-> link.frame && !link.bit_en)
        else $error("request issued while frame bits were still arriving");

endmodule

// ==== design/mem_access.sv ====
`timescale 1ns/1ns

module mem_access
    import eeprom_pkg::*;
#(
    parameter int ADDR_W = 11
)
(
    input  logic       scl,
    input  logic       rst,
    input  logic       req_valid,
    input  mem_req_t   req,
    output logic       rd_valid,
    output logic [7:0] rd_data
);

    logic [7:0]        mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] addr;

    assign addr = req.addr[ADDR_W-1:0];

    always_ff @(posedge scl)
    begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= req_valid && !req.wr;
    end

    always_ff @(posedge scl)
    begin
        if (req_valid)
        begin
            if (req.wr)
                mem[addr] <= req.wdata;
            else
                rd_data <= mem[addr];
        end
    end

endmodule

// ==== design/read_shifter.sv ====
`timescale 1ns/1ns

module read_shifter (
    input  logic       scl,
    input  logic       rst,
    input  logic       rd_valid,
    input  logic [7:0] rd_data,
    serial_if.slave    link
);

    logic [7:0] ret_sr;
    logic [2:0] ret_cnt;

    // msb goes out first
    assign link.ret_sda = ret_sr[7];

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            link.ret_en <= 1'b0;
            ret_cnt     <= '0;
        end
        else if (rd_valid)
        begin
            link.ret_en <= 1'b1;
            ret_cnt     <= '0;
        end
        else if (link.ret_en)
        begin
            ret_cnt <= ret_cnt + 3'd1;
            if (ret_cnt == 3'd7)
                link.ret_en <= 1'b0;
        end
    end

    always_ff @(posedge scl)
    begin
        if (rd_valid)
            ret_sr <= rd_data;
        else if (link.ret_en)
            ret_sr <= {ret_sr[6:0], 1'b0};
    end

    assert property (@(posedge scl) disable iff (rst) rd_valid |-> !link.ret_en)
        else $error("read data arrived during a return");

endmodule

// ==== design/serial_if.sv ====
`timescale 1ns/1ns

interface serial_if;

    // master to slave
    logic frame;
    logic bit_en;
    logic sda;

    // slave to master
    logic nak;
    logic ret_en;
    logic ret_sda;

    modport master (
        output frame,
        output bit_en,
        output sda,
        input  nak,
        input  ret_en,
        input  ret_sda
    );

    // nak from the decoder and the return pair from the read shifter
    modport slave (
        input  frame,
        input  bit_en,
        input  sda,
        output nak,
        output ret_en,
        output ret_sda
    );

endinterface

// ==== eeprom_sys.f ====
design/eeprom_pkg.sv
design/serial_if.sv
design/bus_master.sv
design/frame_decoder.sv
design/mem_access.sv
design/read_shifter.sv
design/eeprom_sys.sv
verif/eeprom_sys_tb.sv

// ==== verif/eeprom_sys_tb.sv ====
`timescale 1ns/1ns

module eeprom_sys_tb;

    localparam int         addr_w     = 11;
    localparam int         wait_limit = 200;
    localparam logic [3:0] dev_code   = 4'b1010;

    logic       scl;
    logic       rst;
    logic       cmd_valid;
    logic [7:0] cmd_ctrl;
    logic [7:0] cmd_addr;
    logic [7:0] cmd_wdata;
    logic       busy;
    logic       rd_valid;
    logic [7:0] rd_data;
    logic       nack;

    // reference memory and pending responses
    // bit 8 of a pending response marks a nack
    logic [7:0] ref_mem [int];
    logic [8:0] exp_q [$];
    logic [10:0] wr_keys [$];
    int         chk_cnt;
    int         err_cnt;
    integer     seed;

    eeprom_sys #(.ADDR_W(addr_w)) DUT (
        .scl       (scl),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd_ctrl  (cmd_ctrl),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .nack      (nack)
    );

    always #2 scl = ~scl;

    function automatic logic [7:0] ctrl_byte(input logic [3:0] dev, input logic [2:0] blk,
                                             input logic rd);
        return {dev, blk, rd};
    endfunction

    // block bits 3..1 of the control byte on top of the address byte
    function automatic int mem_key(input logic [7:0] ctrl, input logic [7:0] addr);
        logic [10:0] full;
        full = {ctrl[3:1], addr};
        return int'(full) % (1 << addr_w);
    endfunction

    function automatic logic [7:0] expect_read(input logic [7:0] ctrl, input logic [7:0] addr);
        int key;
        key = mem_key(ctrl, addr);
        return ref_mem.exists(key) ? ref_mem[key] : 8'hxx;
    endfunction

    task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                         input string what);
        chk_cnt++;
        if (actual !== expected)
        begin
            err_cnt++;
            $display("FAILED at %0t: %s, got %02h, expected %02h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic end_run;
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic wait_busy(input string what);
        int cnt;
        cnt = 0;
        while (!busy && cnt < wait_limit)
        begin
            @(negedge scl);
            cnt++;
        end
        if (!busy)
        begin
            $display("timeout: busy never rose for %s", what);
            err_cnt++;
            end_run();
        end
    endtask

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while (busy && cnt < wait_limit)
        begin
            @(negedge scl);
            cnt++;
        end
        if (busy)
        begin
            $display("timeout: busy stayed high after %s", what);
            err_cnt++;
            end_run();
        end
    endtask

    // drive one command and record its expected outcome
    task automatic issue(input logic [7:0] ctrl, input logic [7:0] addr,
                         input logic [7:0] wdata);
        @(negedge scl);
        cmd_ctrl  = ctrl;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_valid = 1'b1;
        if (ctrl[7:4] != dev_code)
            exp_q.push_back({1'b1, 8'h00});
        else if (ctrl[0])
            exp_q.push_back({1'b0, expect_read(ctrl, addr)});
        else
            ref_mem[mem_key(ctrl, addr)] = wdata;
        @(negedge scl);
        cmd_valid = 1'b0;
    endtask

    task automatic run_cmd(input logic [7:0] ctrl, input logic [7:0] addr,
                           input logic [7:0] wdata, input string what);
        issue(ctrl, addr, wdata);
        wait_busy(what);
        wait_idle(what);
    endtask

    // command sent while busy and expected to be ignored
    task automatic pulse_ignored(input logic [7:0] ctrl, input logic [7:0] addr,
                                 input logic [7:0] wdata);
        @(negedge scl);
        check({7'b0, busy}, 8'h01, "busy during ignored command");
        cmd_ctrl  = ctrl;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        cmd_valid = 1'b1;
        @(negedge scl);
        cmd_valid = 1'b0;
    endtask

    task automatic drain;
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < wait_limit)
        begin
            @(negedge scl);
            cnt++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout: %0d expected responses never arrived", exp_q.size());
            err_cnt++;
        end
        // quiet period to catch stray pulses
        for (int i = 0; i < 20; i++)
            @(negedge scl);
    endtask

    always @(negedge scl)
    begin
        logic [8:0] exp_v;
        if (!rst && (rd_valid || nack))
        begin
            if (exp_q.size() == 0)
            begin
                err_cnt++;
                $display("unexpected response at %0t: rd_valid=%0b nack=%0b",
                         $time, rd_valid, nack);
            end
            else
            begin
                exp_v = exp_q.pop_front();
                check({7'b0, nack}, {7'b0, exp_v[8]}, "nack flag");
                check({7'b0, rd_valid}, {7'b0, !exp_v[8]}, "rd_valid flag");
                if (!exp_v[8])
                    check(rd_data, exp_v[7:0], "read data");
            end
        end
    end

    initial
    begin
        integer      r;
        int          idx;
        logic [10:0] key;
        scl       = 1'b0;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_ctrl  = 8'h00;
        cmd_addr  = 8'h00;
        cmd_wdata = 8'h00;
        chk_cnt   = 0;
        err_cnt   = 0;
        seed      = 32'hca7787fe;
        repeat (10) @(negedge scl);
        rst = 1'b0;

        @(negedge scl);
        check({7'b0, busy}, 8'h00, "busy after reset");
        check({7'b0, rd_valid}, 8'h00, "rd_valid after reset");
        check({7'b0, nack}, 8'h00, "nack after reset");
        run_cmd(ctrl_byte(dev_code, 3'd2, 1'b0), 8'h5a, 8'hc3, "first write");
        run_cmd(ctrl_byte(dev_code, 3'd2, 1'b1), 8'h5a, 8'h00, "first read");

        // same address byte in every block
        for (int b = 0; b < 8; b++)
            run_cmd(ctrl_byte(dev_code, 3'(b), 1'b0), 8'h3c, {3'(b), 5'b10110}, "block write");
        for (int b = 0; b < 8; b++)
            run_cmd(ctrl_byte(dev_code, 3'(b), 1'b1), 8'h3c, 8'h00, "block read");

        run_cmd(ctrl_byte(dev_code, 3'd5, 1'b0), 8'h81, 8'h77, "target write");
        run_cmd(ctrl_byte(4'b1011, 3'd5, 1'b0), 8'h81, 8'h99, "bad type write");
        run_cmd(ctrl_byte(4'b0010, 3'd5, 1'b1), 8'h81, 8'h00, "bad type read");
        run_cmd(ctrl_byte(dev_code, 3'd5, 1'b1), 8'h81, 8'h00, "read after nack");

        run_cmd(ctrl_byte(dev_code, 3'd1, 1'b0), 8'h20, 8'h11, "pre-write");
        issue(ctrl_byte(dev_code, 3'd6, 1'b0), 8'h44, 8'hab);
        wait_busy("write with overlap");
        pulse_ignored(ctrl_byte(dev_code, 3'd1, 1'b0), 8'h20, 8'hee);
        pulse_ignored(ctrl_byte(dev_code, 3'd1, 1'b1), 8'h20, 8'h00);
        wait_idle("write with overlap");
        run_cmd(ctrl_byte(dev_code, 3'd6, 1'b1), 8'h44, 8'h00, "read of accepted write");
        run_cmd(ctrl_byte(dev_code, 3'd1, 1'b1), 8'h20, 8'h00, "read of ignored target");

        for (int n = 0; n < 50; n++)
        begin
            r = $random(seed);
            run_cmd(ctrl_byte(dev_code, r[2:0], 1'b0), r[10:3], r[18:11], "random write");
            wr_keys.push_back(r[10:0]);
            r   = $random(seed);
            idx = $unsigned(r) % wr_keys.size();
            key = wr_keys[idx];
            run_cmd(ctrl_byte(dev_code, key[2:0], 1'b1), key[10:3], 8'h00, "random read");
        end

        drain();
        end_run();
    end

endmodule
